//--- hw/shuffle_pkg.sv
////////////////////////////////////////
// Shuffle package
// Sizes, width types, element width
// encoding and the read beat struct shared
// by the read shuffler
////////////////////////////////////////

package shuffle_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Lanes per cluster and number of clusters
  localparam int unsigned NrLanes      = 2;
  localparam int unsigned NrClusters   = 4;

  // Data bits seen by one cluster and by the memory port
  localparam int unsigned ClusterWidth = 64;
  localparam int unsigned BeatWidth    = NrClusters * ClusterWidth;

  // One stage per doubling of the block size up to a full cluster slot
  localparam int unsigned NumStages    = $clog2(ClusterWidth / (8 * NrLanes));

  // Outstanding read requests
  localparam int unsigned NumTrackers  = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [BeatWidth-1:0]    beat_data_t;
  typedef logic [ClusterWidth-1:0] cluster_data_t;
  typedef logic [2:0]              trk_pnt_t;
  typedef logic [3:0]              trk_cnt_t;
  typedef logic [NumStages-1:0]    stage_en_t;

  // Element width of a read request, code 3 is not legal
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } vew_e;

  // Read beat as returned by memory
  typedef struct packed {
    beat_data_t data;
    logic       last;
  } r_beat_t;

endpackage

//--- hw/read_tracker.sv
////////////////////////////////////////
// Read request tracker
// Queues the element width of each read
// request and hands every shuffle stage
// the width of the request it works on
////////////////////////////////////////

module read_tracker import shuffle_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Read request channel
  input  logic      ar_valid_i,
  input  vew_e      ar_vew_i,
  output logic      ar_ready_o,
  // Shuffle stage interface
  input  stage_en_t stage_done_i,
  output stage_en_t stage_en_o
);

  vew_e                     trk_q [NumTrackers];
  trk_pnt_t                 accept_pnt_q;
  trk_pnt_t [NumStages-1:0] issue_pnt_q;
  trk_cnt_t                 cnt_q;
  logic                     push;
  logic                     pop;

  // Full when every entry holds a request
  assign ar_ready_o = (cnt_q != trk_cnt_t'(NumTrackers));
  assign push       = ar_valid_i & ar_ready_o;

  // An entry is freed once the final stage is done with it
  assign pop        = stage_done_i[NumStages-1];

  ////////////////////////////////////////
  // Queue and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // EW32 entries disable every stage
      trk_q        <= '{default: EW32};
      accept_pnt_q <= '0;
      cnt_q        <= '0;
    end else begin
      if (push) begin
        trk_q[accept_pnt_q] <= ar_vew_i;
        accept_pnt_q        <= trk_pnt_t'(accept_pnt_q + 1);
      end
      unique case ({push, pop})
        2'b10:   cnt_q <= trk_cnt_t'(cnt_q + 1);
        2'b01:   cnt_q <= trk_cnt_t'(cnt_q - 1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Each stage walks the queue on its own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_pnt_q <= '0;
    end else begin
      for (int s = 0; s < NumStages; s++) begin
        if (stage_done_i[s]) begin
          issue_pnt_q[s] <= trk_pnt_t'(issue_pnt_q[s] + 1);
        end
      end
    end
  end

  // Stage s shuffles for widths up to code s
  for (genvar s = 0; s < NumStages; s++) begin : gen_stage_en
    assign stage_en_o[s] = (s >= int'(trk_q[issue_pnt_q[s]]));
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_legal_vew : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> ar_vew_i inside {EW8, EW16, EW32})
    else $error("read_tracker: illegal element width accepted");

  a_done_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|stage_done_i) |-> (cnt_q != '0))
    else $error("read_tracker: stage done with no request outstanding");

endmodule

//--- hw/shuffle_net.sv
////////////////////////////////////////
// Shuffle network
// Block gather for one read shuffle stage,
// block size doubles with each stage
////////////////////////////////////////

module shuffle_net import shuffle_pkg::*; #(
  parameter int unsigned stage_i = 0
) (
  input  beat_data_t data_i,
  input  logic       enable_i,
  output beat_data_t data_o
);

  // Stage 0 moves 16 bit blocks
  localparam int unsigned BlockSize   = (8 * NrLanes) << stage_i;
  localparam int unsigned GroupBlocks = 2 * NrClusters;
  localparam int unsigned NumGroups   = BeatWidth / (BlockSize * GroupBlocks);

  beat_data_t gathered;

  // Output block 2i+j of a group takes input block j*NrClusters+i
  always_comb begin
    gathered = data_i;
    for (int k = 0; k < NumGroups; k++) begin
      for (int i = 0; i < NrClusters; i++) begin
        for (int j = 0; j < 2; j++) begin
          gathered[(k * GroupBlocks + 2 * i + j) * BlockSize +: BlockSize] =
            data_i[(k * GroupBlocks + j * NrClusters + i) * BlockSize +: BlockSize];
        end
      end
    end
  end

  // Wide elements skip this stage
  assign data_o = enable_i ? gathered : data_i;

endmodule

//--- hw/shuffle_pipe.sv
////////////////////////////////////////
// Shuffle pipeline
// Two shuffle stages split by a stream
// register, with per-stage done pulses
////////////////////////////////////////

module shuffle_pipe import shuffle_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Memory side
  input  logic      in_valid_i,
  input  r_beat_t   in_beat_i,
  output logic      in_ready_o,
  // Tracker side
  input  stage_en_t stage_en_i,
  output stage_en_t stage_done_o,
  // Cluster side
  output logic      out_valid_o,
  output r_beat_t   out_beat_o,
  input  logic      out_ready_i
);

  r_beat_t s0_beat;
  r_beat_t beat_q;
  logic    valid_q;

  ////////////////////////////////////////
  // Stage 0
  ////////////////////////////////////////

  shuffle_net #(
    .stage_i (0)
  ) i_shuffle_net_0 (
    .data_i   (in_beat_i.data),
    .enable_i (stage_en_i[0]),
    .data_o   (s0_beat.data)
  );

  assign s0_beat.last = in_beat_i.last;

  ////////////////////////////////////////
  // Stream register
  ////////////////////////////////////////

  // Takes a new beat when empty or draining
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      beat_q <= s0_beat;
    end
  end

  ////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////

  shuffle_net #(
    .stage_i (1)
  ) i_shuffle_net_1 (
    .data_i   (beat_q.data),
    .enable_i (stage_en_i[NumStages-1]),
    .data_o   (out_beat_o.data)
  );

  assign out_beat_o.last = beat_q.last;
  assign out_valid_o     = valid_q;

  // A stage is done with a request when its last beat moves on
  assign stage_done_o[0]           = in_valid_i & in_ready_o & in_beat_i.last;
  assign stage_done_o[NumStages-1] = valid_q & out_ready_i & beat_q.last;

  // Stalled output holds, including the width used by stage 1
  a_stall_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
    else $error("shuffle_pipe: output beat changed while stalled");

endmodule

//--- hw/cluster_fork.sv
////////////////////////////////////////
// Cluster fork
// Offers each beat to all clusters and
// retires it once every cluster took it
////////////////////////////////////////

module cluster_fork import shuffle_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Pipeline side
  input  logic                  valid_i,
  output logic                  ready_o,
  // Cluster side
  output logic [NrClusters-1:0] r_valid_o,
  input  logic [NrClusters-1:0] r_ready_i
);

  // One bit per cluster that already accepted the current beat
  logic [NrClusters-1:0] taken_q;
  logic [NrClusters-1:0] taken_d;

  assign r_valid_o = {NrClusters{valid_i}} & ~taken_q;

  // Last outstanding cluster completes the beat
  assign ready_o   = &(r_ready_i | taken_q);

  always_comb begin
    if (valid_i && ready_o) begin
      taken_d = '0;
    end else begin
      taken_d = taken_q | (r_valid_o & r_ready_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_d;
    end
  end

  // A taken beat stays pending but is no longer offered to that cluster
  for (genvar c = 0; c < NrClusters; c++) begin : gen_chk
    a_once : assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o[c] && r_ready_i[c] && !ready_o |=> valid_i && !r_valid_o[c])
      else $error("cluster_fork: cluster %0d offered a taken beat", c);
  end

endmodule

//--- hw/shuffle_stage.sv
////////////////////////////////////////
// Read shuffle stage, top level
// Permutes memory read beats so every
// cluster receives its lanes' elements
////////////////////////////////////////

module shuffle_stage import shuffle_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Read request channel
  input  logic                  ar_valid_i,
  input  vew_e                  ar_vew_i,
  output logic                  ar_ready_o,
  // Memory beat channel
  input  logic                  r_valid_i,
  input  r_beat_t               r_beat_i,
  output logic                  r_ready_o,
  // Cluster channel, cluster c reads data slice c
  output logic [NrClusters-1:0] r_valid_o,
  input  logic [NrClusters-1:0] r_ready_i,
  output r_beat_t               r_beat_o
);

  stage_en_t stage_en;
  stage_en_t stage_done;
  logic      pipe_valid;
  logic      pipe_ready;
  r_beat_t   pipe_beat;

  read_tracker i_read_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ar_valid_i   (ar_valid_i),
    .ar_vew_i     (ar_vew_i),
    .ar_ready_o   (ar_ready_o),
    .stage_done_i (stage_done),
    .stage_en_o   (stage_en)
  );

  shuffle_pipe i_shuffle_pipe (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (r_valid_i),
    .in_beat_i    (r_beat_i),
    .in_ready_o   (r_ready_o),
    .stage_en_i   (stage_en),
    .stage_done_o (stage_done),
    .out_valid_o  (pipe_valid),
    .out_beat_o   (pipe_beat),
    .out_ready_i  (pipe_ready)
  );

  cluster_fork i_cluster_fork (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (pipe_valid),
    .ready_o   (pipe_ready),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i)
  );

  // Beat is shared, each cluster picks its own slice
  assign r_beat_o = pipe_beat;

endmodule

//--- verif/shuffle_model.svh
////////////////////////////////////////
// Shuffle reference model
// Element to cluster mapping used by the
// testbench scoreboard
////////////////////////////////////////

`ifndef SHUFFLE_MODEL_SVH
`define SHUFFLE_MODEL_SVH

// Beat element that lands in slot k of cluster c
function automatic int unsigned src_element(int unsigned c, int unsigned k);
  return (k / NrLanes) * NrLanes * NrClusters + c * NrLanes + (k % NrLanes);
endfunction

// Whole beat as the clusters should see it
function automatic beat_data_t expected_beat(beat_data_t data, vew_e vew);
  beat_data_t  res;
  int unsigned ew;
  int unsigned src;
  ew  = 8 << int'(vew);
  res = '0;
  for (int unsigned c = 0; c < NrClusters; c++) begin
    for (int unsigned k = 0; k < ClusterWidth / ew; k++) begin
      src = src_element(c, k);
      for (int unsigned b = 0; b < ew; b++) begin
        res[c * ClusterWidth + k * ew + b] = data[src * ew + b];
      end
    end
  end
  return res;
endfunction

// Random payload for one memory beat
function automatic beat_data_t random_data();
  beat_data_t res;
  for (int i = 0; i < BeatWidth / 32; i++) begin
    res[i * 32 +: 32] = $urandom();
  end
  return res;
endfunction

`endif

//--- verif/tb_shuffle_stage.sv
////////////////////////////////////////
// Read shuffle testbench
// Random requests and beats checked by a
// scoreboard, with stalling clusters
////////////////////////////////////////

module tb_shuffle_stage import shuffle_pkg::*; ();

  localparam int unsigned NumReq = 40;
  localparam int unsigned Seed   = 32'h87674b16;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  ar_valid_i;
  vew_e                  ar_vew_i;
  logic                  ar_ready_o;
  logic                  r_valid_i;
  r_beat_t               r_beat_i;
  logic                  r_ready_o;
  logic [NrClusters-1:0] r_valid_o;
  logic [NrClusters-1:0] r_ready_i;
  r_beat_t               r_beat_o;

  // Request list and scoreboard state
  vew_e        req_vew [NumReq];
  int unsigned req_len [NumReq];
  int unsigned got [NrClusters] = '{default: 0};
  int unsigned total_beats = 0;
  int unsigned req_acc = 0;
  int unsigned r_req = 0;
  int unsigned beat_in_req = 0;
  int unsigned outstanding = 0;
  int unsigned retired = 0;
  logic        ar_hs = 1'b0;
  logic        r_hs = 1'b0;
  logic        beats_open = 1'b0;
  vew_e        width_q [$];
  beat_data_t  exp_data_q [$];
  logic        exp_last_q [$];

  `include "shuffle_model.svh"

  shuffle_stage i_shuffle_stage (.*);

  always #5 clk_i = ~clk_i;

  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Stimulus, driven on the falling edge
  ////////////////////////////////////////

  task automatic drive_inputs();
    // An offer stays up until it is taken
    if (!ar_valid_i || ar_hs) begin
      ar_valid_i = (req_acc < NumReq) && ($urandom_range(0, 3) != 0);
      if (ar_valid_i) begin
        ar_vew_i = req_vew[req_acc];
      end
    end
    // Beats only for requests the tracker already holds
    if (!r_valid_i || r_hs) begin
      r_valid_i = beats_open && (r_req < req_acc) && ($urandom_range(0, 3) != 0);
      if (r_valid_i) begin
        r_beat_i.data = random_data();
        r_beat_i.last = (beat_in_req == req_len[r_req] - 1);
      end
    end
    for (int c = 0; c < NrClusters; c++) begin
      r_ready_i[c] = ($urandom_range(0, 3) != 0);
    end
  endtask

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////

  task automatic sample_outputs();
    int unsigned           idx;
    int unsigned           min_got;
    cluster_data_t         exp_slice;
    cluster_data_t         got_slice;
    logic                  pending;
    logic                  exp_ready;
    logic [NrClusters-1:0] taken;
    assert (ar_ready_o == (outstanding < NumTrackers))
      else report_fail($sformatf("Fail ar_ready_o: expected %h, got %h",
                                 outstanding < NumTrackers, ar_ready_o));
    // Beats are held back until the tracker has filled up once
    if (!ar_ready_o) begin
      beats_open = 1'b1;
    end
    // Beat taken last cycle is offered to every cluster now
    if (r_hs) begin
      assert (r_valid_o == {NrClusters{1'b1}})
        else report_fail($sformatf("Fail r_valid_o: expected %h, got %h",
                                   {NrClusters{1'b1}}, r_valid_o));
    end
    // Clusters that already took the pending beat must not see it again
    pending = (exp_data_q.size() > retired);
    for (int c = 0; c < NrClusters; c++) begin
      taken[c] = (got[c] > retired);
    end
    assert (r_valid_o == ({NrClusters{pending}} & ~taken))
      else report_fail($sformatf("Fail r_valid_o: expected %h, got %h",
                                 {NrClusters{pending}} & ~taken, r_valid_o));
    // Memory stalls while the pending beat cannot retire
    exp_ready = !pending || (&(r_ready_i | taken));
    assert (r_ready_o == exp_ready)
      else report_fail($sformatf("Fail r_ready_o: expected %h, got %h",
                                 exp_ready, r_ready_o));
    for (int c = 0; c < NrClusters; c++) begin
      if (r_valid_o[c] && r_ready_i[c]) begin
        idx = got[c];
        assert (idx < exp_data_q.size())
          else report_fail($sformatf("Cluster %0d received a beat that was never sent", c));
        exp_slice = exp_data_q[idx][c * ClusterWidth +: ClusterWidth];
        got_slice = r_beat_o.data[c * ClusterWidth +: ClusterWidth];
        assert (got_slice == exp_slice)
          else report_fail($sformatf("Fail r_beat_o.data[%0d]: expected %h, got %h",
                                     c, exp_slice, got_slice));
        assert (r_beat_o.last == exp_last_q[idx])
          else report_fail($sformatf("Fail r_beat_o.last: expected %h, got %h",
                                     exp_last_q[idx], r_beat_o.last));
        got[c]++;
      end
    end
    // Retire what every cluster has taken
    min_got = got[0];
    for (int c = 1; c < NrClusters; c++) begin
      if (got[c] < min_got) begin
        min_got = got[c];
      end
    end
    while (retired < min_got) begin
      if (exp_last_q[retired]) begin
        outstanding--;
      end
      retired++;
    end
    ar_hs = ar_valid_i && ar_ready_o;
    if (ar_hs) begin
      width_q.push_back(ar_vew_i);
      req_acc++;
      outstanding++;
    end
    r_hs = r_valid_i && r_ready_o;
    if (r_hs) begin
      exp_data_q.push_back(expected_beat(r_beat_i.data, width_q[0]));
      exp_last_q.push_back(r_beat_i.last);
      beat_in_req++;
      if (r_beat_i.last) begin
        void'(width_q.pop_front());
        r_req++;
        beat_in_req = 0;
      end
    end
  endtask

  initial begin : stimulus
    void'($urandom(Seed));
    rst_ni     = 1'b0;
    ar_valid_i = 1'b0;
    ar_vew_i   = EW8;
    r_valid_i  = 1'b0;
    r_beat_i   = '0;
    r_ready_i  = '0;
    for (int i = 0; i < NumReq; i++) begin
      req_vew[i]   = vew_e'($urandom_range(0, 2));
      req_len[i]   = $urandom_range(1, 4);
      total_beats += req_len[i];
    end
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    assert (ar_ready_o && r_valid_o == '0)
      else report_fail("Tracker not ready or a cluster valid is high after reset");
    while (retired < total_beats) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      sample_outputs();
    end
    // Fully drained, nothing may be offered any more
    repeat (2) @(negedge clk_i);
    assert (r_valid_o == '0 && ar_ready_o)
      else report_fail("Beats or requests remain after the last beat retired");
    $display("Simulation passed");
    $finish;
  end

  initial begin : watchdog
    wait (total_beats != 0);
    repeat (total_beats * 40) @(posedge clk_i);
    report_fail("Timeout, beats stopped reaching the clusters");
  end

endmodule

//--- shuffle_stage.f
+incdir+verif
hw/shuffle_pkg.sv
hw/read_tracker.sv
hw/shuffle_net.sv
hw/shuffle_pipe.sv
hw/cluster_fork.sv
hw/shuffle_stage.sv
verif/tb_shuffle_stage.sv
